// File: mpu_map_pkg.sv
// Bus widths, region bases and register offsets of the peripheral map, shared by decoder and testbench
package mpu_map_pkg;

	localparam int data_w = 32;
	localparam int addr_w = 32;

	typedef logic [data_w-1:0] bus_word_t;

	// Upper 24 address bits of each region
	localparam logic [addr_w-9:0] periph_base = 24'hFFFFFF;
	localparam logic [addr_w-9:0] bridge_base = 24'hF00000; // Host mailbox window

	typedef enum logic [7:0] {
		mailbox_0      = 8'h00,
		mailbox_1      = 8'h04,
		mailbox_2      = 8'h08,
		mailbox_3      = 8'h0C,
		mailbox_4      = 8'h10,
		mailbox_5      = 8'h14,
		mailbox_6      = 8'h18,
		mailbox_7      = 8'h1C,
		core_in        = 8'h50,
		core_out       = 8'h54,
		ds_id          = 8'h80,
		ds_bridge_addr = 8'h84,
		ds_length      = 8'h88,
		ds_slot_offset = 8'h8C,
		ds_ctrl        = 8'h90, // Go bits on write, status on read
		uart_divisor   = 8'h94,
		ticks_per_ms   = 8'h98,
		uart_data      = 8'hC0,
		timer_count    = 8'hC4, // Bit 0 set clears and stops the timer
		timer_limit    = 8'hC8,
		irq_mask       = 8'hF4
	} reg_offset_e;

	// ds_ctrl write bits
	localparam int read_go_bit    = 0;
	localparam int write_go_bit   = 1;
	localparam int irq_enable_bit = 2;

endpackage

// File: mpu_periph_pkg.sv
// Types and constants of the UART transmit path, used by the FIFO, serializer and decoder
package mpu_periph_pkg;

	// Data bits per UART frame
	localparam int frame_bits = 8;

	typedef logic [frame_bits-1:0] uart_byte_t;

	// Serializer holds a single buffered byte
	localparam int tx_credits = 1;

	typedef enum logic [1:0] {
		tx_idle,  // Line held high
		tx_start, // Low start bit
		tx_data,  // LSB first
		tx_stop   // High stop bit
	} tx_state_e;

endpackage

// File: timer_ctrl_if.sv
// Control and status link between the register decoder and the millisecond timer
interface timer_ctrl_if;

	logic                   clear;        // One-cycle strobe
	mpu_map_pkg::bus_word_t limit;
	logic                   limit_load;   // One-cycle strobe
	mpu_map_pkg::bus_word_t ticks_per_ms;
	mpu_map_pkg::bus_word_t ms_count;
	logic                   irq;          // Sticky until clear

	modport decoder (output clear, limit, limit_load, ticks_per_ms, input ms_count, irq);

	modport timer (input clear, limit, limit_load, ticks_per_ms, output ms_count, irq);

endinterface

// File: mpu_reg_decoder.sv
// Register file of the peripheral block, answering CPU and bridge accesses and driving the peripherals
module mpu_reg_decoder (
	input  logic                             clk_sys,
	input  logic                             reset_n,
	input  logic                             cmd_valid,
	input  logic                             cmd_wr,
	input  logic [mpu_map_pkg::addr_w-1:0]   cmd_addr,
	input  mpu_map_pkg::bus_word_t           cmd_data,
	output logic                             rsp_ready,
	output mpu_map_pkg::bus_word_t           rsp_data,
	input  logic                             bridge_wr,
	input  logic                             bridge_rd,
	input  logic [mpu_map_pkg::addr_w-1:0]   bridge_addr,
	input  mpu_map_pkg::bus_word_t           bridge_wr_data,
	output mpu_map_pkg::bus_word_t           bridge_rd_data,
	output logic                             target_dataslot_read,
	output logic                             target_dataslot_write,
	input  logic                             target_dataslot_ack,
	input  logic                             target_dataslot_done,
	input  logic [2:0]                       target_dataslot_err,
	output logic [15:0]                      target_dataslot_id,
	output mpu_map_pkg::bus_word_t           target_dataslot_bridge_addr,
	output mpu_map_pkg::bus_word_t           target_dataslot_length,
	output mpu_map_pkg::bus_word_t           target_dataslot_slot_offset,
	input  mpu_map_pkg::bus_word_t           core_input,
	output mpu_map_pkg::bus_word_t           core_output,
	output logic                             ext_irq,
	output logic                             timer_irq,
	timer_ctrl_if.decoder                    timer,
	output logic                             push,
	output mpu_periph_pkg::uart_byte_t       push_byte,
	input  logic                             full,
	output mpu_map_pkg::bus_word_t           uart_divisor
);

	mpu_map_pkg::bus_word_t mailbox [8];
	mpu_map_pkg::bus_word_t rd_word;
	mpu_map_pkg::bus_word_t br_rd_q;       // First bridge read stage
	mpu_map_pkg::reg_offset_e cpu_off;
	mpu_map_pkg::reg_offset_e br_off;
	logic       cpu_hit, cpu_wr, cpu_rd, cpu_mb;
	logic       br_hit, br_mb;
	logic [2:0] cpu_idx, br_idx;
	logic       done_q;
	logic       ds_irq_en;
	logic       timer_en;
	logic       irq_mask_q;

	assign cpu_hit = cmd_valid && (cmd_addr[mpu_map_pkg::addr_w-1:8] == mpu_map_pkg::periph_base);
	assign cpu_wr  = cpu_hit && cmd_wr;
	assign cpu_rd  = cpu_hit && !cmd_wr;
	assign cpu_off = mpu_map_pkg::reg_offset_e'(cmd_addr[7:0]);
	assign cpu_idx = cmd_addr[4:2];
	assign cpu_mb  = (cpu_off inside {[mpu_map_pkg::mailbox_0 : mpu_map_pkg::mailbox_7]})
		&& (cmd_addr[1:0] == 2'b00);

	assign br_hit = bridge_addr[mpu_map_pkg::addr_w-1:8] == mpu_map_pkg::bridge_base;
	assign br_off = mpu_map_pkg::reg_offset_e'(bridge_addr[7:0]);
	assign br_idx = bridge_addr[4:2];
	assign br_mb  = br_hit && (br_off inside {[mpu_map_pkg::mailbox_0 : mpu_map_pkg::mailbox_7]})
		&& (bridge_addr[1:0] == 2'b00);

	// CPU read mux
	always_comb begin
		rd_word = '0;
		if (cpu_mb) begin
			rd_word = mailbox[cpu_idx];
		end else begin
			case (cpu_off)
				mpu_map_pkg::core_in:        rd_word = core_input;
				mpu_map_pkg::core_out:       rd_word = core_output;
				mpu_map_pkg::ds_id:          rd_word = {16'd0, target_dataslot_id};
				mpu_map_pkg::ds_bridge_addr: rd_word = target_dataslot_bridge_addr;
				mpu_map_pkg::ds_length:      rd_word = target_dataslot_length;
				mpu_map_pkg::ds_slot_offset: rd_word = target_dataslot_slot_offset;
				mpu_map_pkg::ds_ctrl: begin
					rd_word = {27'd0, target_dataslot_ack, target_dataslot_done, target_dataslot_err};
				end
				mpu_map_pkg::uart_divisor:   rd_word = uart_divisor;
				mpu_map_pkg::ticks_per_ms:   rd_word = timer.ticks_per_ms;
				mpu_map_pkg::uart_data:      rd_word = {23'd0, full, 8'd0}; // Full flag at bit 8
				mpu_map_pkg::timer_count:    rd_word = timer.ms_count;
				mpu_map_pkg::timer_limit:    rd_word = timer.limit;
				mpu_map_pkg::irq_mask:       rd_word = {28'd0, irq_mask_q, timer.irq, timer_irq, timer_en};
				default:                     rd_word = '0;
			endcase
		end
	end

	// Mailboxes, response data and bridge read pipeline
	always_ff @(posedge clk_sys) begin
		for (int i = 0; i < 8; i++) begin
			if (bridge_wr && br_mb && (br_idx == i)) begin
				mailbox[i] <= bridge_wr_data; // Bridge wins a collision
			end else if (cpu_wr && cpu_mb && (cpu_idx == i)) begin
				mailbox[i] <= cmd_data;
			end
		end
		rsp_data <= cpu_rd ? rd_word : '0;
		if (bridge_rd) begin
			br_rd_q <= br_mb ? mailbox[br_idx] : '0;
		end
		bridge_rd_data <= br_rd_q;
		if (cpu_wr && (cpu_off == mpu_map_pkg::uart_data)) begin
			push_byte <= cmd_data[7:0];
		end
	end

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			rsp_ready                   <= 1'b0;
			target_dataslot_read        <= 1'b0;
			target_dataslot_write       <= 1'b0;
			target_dataslot_id          <= '0;
			target_dataslot_bridge_addr <= '0;
			target_dataslot_length      <= '0;
			target_dataslot_slot_offset <= '0;
			core_output                 <= '0;
			uart_divisor                <= '0;
			ext_irq                     <= 1'b0;
			timer_irq                   <= 1'b0;
			push                        <= 1'b0;
			done_q                      <= 1'b0;
			ds_irq_en                   <= 1'b0;
			timer_en                    <= 1'b0;
			irq_mask_q                  <= 1'b0;
			timer.clear                 <= 1'b0;
			timer.limit                 <= '0;
			timer.limit_load            <= 1'b0;
			timer.ticks_per_ms          <= '0;
		end else begin
			rsp_ready             <= cmd_valid; // Every command answers next cycle
			target_dataslot_read  <= 1'b0;
			target_dataslot_write <= 1'b0;
			push                  <= 1'b0;
			timer.clear           <= 1'b0;
			timer.limit_load      <= 1'b0;
			done_q                <= target_dataslot_done;
			ext_irq               <= ds_irq_en && target_dataslot_done && !done_q;
			timer_irq             <= timer.irq && timer_en && irq_mask_q;
			if (cpu_wr) begin
				case (cpu_off)
					mpu_map_pkg::core_out:       core_output <= cmd_data;
					mpu_map_pkg::ds_id:          target_dataslot_id <= cmd_data[15:0];
					mpu_map_pkg::ds_bridge_addr: target_dataslot_bridge_addr <= cmd_data;
					mpu_map_pkg::ds_length:      target_dataslot_length <= cmd_data;
					mpu_map_pkg::ds_slot_offset: target_dataslot_slot_offset <= cmd_data;
					mpu_map_pkg::ds_ctrl: begin
						target_dataslot_read  <= cmd_data[mpu_map_pkg::read_go_bit];
						target_dataslot_write <= cmd_data[mpu_map_pkg::write_go_bit];
						ds_irq_en             <= cmd_data[mpu_map_pkg::irq_enable_bit];
					end
					mpu_map_pkg::uart_divisor:   uart_divisor <= cmd_data;
					mpu_map_pkg::ticks_per_ms:   timer.ticks_per_ms <= cmd_data;
					mpu_map_pkg::uart_data:      push <= !full; // Dropped when full
					mpu_map_pkg::timer_count: begin
						if (cmd_data[0]) begin
							timer.clear <= 1'b1;
							timer_en    <= 1'b0;
						end
					end
					mpu_map_pkg::timer_limit: begin
						timer.limit      <= cmd_data;
						timer.limit_load <= 1'b1;
						timer_en         <= 1'b1;
					end
					mpu_map_pkg::irq_mask:       irq_mask_q <= cmd_data[0];
					default: ;
				endcase
			end
		end
	end

endmodule

// File: ms_timer.sv
// Millisecond timer with a programmable tick length and a sticky limit interrupt
module ms_timer (
	input logic         clk_sys,
	input logic         reset_n,
	timer_ctrl_if.timer ctrl
);

	mpu_map_pkg::bus_word_t tick_cnt;
	mpu_map_pkg::bus_word_t limit_q;
	logic                   ms_tick; // One cycle after each tick wrap

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			tick_cnt      <= '0;
			ms_tick       <= 1'b0;
			limit_q       <= '0;
			ctrl.ms_count <= '0;
			ctrl.irq      <= 1'b0;
		end else if (ctrl.clear) begin
			tick_cnt      <= '0;
			ms_tick       <= 1'b0;
			limit_q       <= '0;
			ctrl.ms_count <= '0;
			ctrl.irq      <= 1'b0;
		end else begin
			// ticks_per_ms + 1 cycles per millisecond
			if (tick_cnt == ctrl.ticks_per_ms) begin
				tick_cnt <= '0;
				ms_tick  <= 1'b1;
			end else begin
				tick_cnt <= tick_cnt + 1'b1;
				ms_tick  <= 1'b0;
			end
			if (ms_tick) begin
				ctrl.ms_count <= ctrl.ms_count + 1'b1;
			end
			if (ctrl.limit_load) begin
				limit_q <= ctrl.limit;
			end
			if ((limit_q != '0) && (ctrl.ms_count >= limit_q)) begin
				ctrl.irq <= 1'b1; // Held until clear
			end
		end
	end

endmodule

// File: uart_tx_fifo.sv
// Transmit byte FIFO that hands bytes to the UART serializer under credit control
module uart_tx_fifo #(
	parameter int fifo_depth = 4
) (
	input  logic                       clk_sys,
	input  logic                       reset_n,
	input  logic                       push,
	input  mpu_periph_pkg::uart_byte_t push_byte,
	output logic                       full,
	output logic                       tx_valid,
	output mpu_periph_pkg::uart_byte_t tx_byte,
	input  logic                       credit_return
);

	localparam int ptr_w    = $clog2(fifo_depth);
	localparam int credit_w = $clog2(mpu_periph_pkg::tx_credits + 1);

	mpu_periph_pkg::uart_byte_t mem [fifo_depth];
	logic [ptr_w-1:0]           rd_ptr, wr_ptr;
	logic [ptr_w:0]             count;
	logic [credit_w-1:0]        credits;
	logic                       do_push;

	assign full     = count == (ptr_w + 1)'(fifo_depth);
	assign do_push  = push && !full;
	assign tx_valid = (count != '0) && (credits != '0); // Head goes out while credit is left
	assign tx_byte  = mem[rd_ptr];

	always_ff @(posedge clk_sys) begin
		if (do_push) begin
			mem[wr_ptr] <= push_byte;
		end
	end

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			rd_ptr  <= '0;
			wr_ptr  <= '0;
			count   <= '0;
			credits <= credit_w'(mpu_periph_pkg::tx_credits);
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1; // Wraps at the power-of-two depth
			end
			if (tx_valid) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, tx_valid})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			case ({tx_valid, credit_return})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

endmodule

// File: uart_tx_serializer.sv
// Frames buffered bytes as 8N1 and shifts them out on txd at the programmed bit period
module uart_tx_serializer (
	input  logic                       clk_sys,
	input  logic                       reset_n,
	input  logic                       tx_valid,
	input  mpu_periph_pkg::uart_byte_t tx_byte,
	output logic                       credit_return,
	input  mpu_map_pkg::bus_word_t     uart_divisor,
	output logic                       txd
);

	mpu_periph_pkg::tx_state_e  state;
	mpu_periph_pkg::uart_byte_t buf_byte;
	mpu_periph_pkg::uart_byte_t shift_q;
	mpu_map_pkg::bus_word_t     bit_cnt;
	logic [$clog2(mpu_periph_pkg::frame_bits)-1:0] bit_idx;
	logic                       buf_full;
	logic                       bit_end;

	assign bit_end       = bit_cnt == (uart_divisor - 1'b1);
	assign credit_return = (state == mpu_periph_pkg::tx_idle) && buf_full; // Buffer moves to shifter

	always_comb begin
		case (state)
			mpu_periph_pkg::tx_start: txd = 1'b0;
			mpu_periph_pkg::tx_data:  txd = shift_q[0];
			default:                  txd = 1'b1; // Idle and stop
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (tx_valid) begin
			buf_byte <= tx_byte;
		end
		if (credit_return) begin
			shift_q <= buf_byte;
		end else if ((state == mpu_periph_pkg::tx_data) && bit_end) begin
			shift_q <= shift_q >> 1;
		end
	end

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			state    <= mpu_periph_pkg::tx_idle;
			buf_full <= 1'b0;
			bit_cnt  <= '0;
			bit_idx  <= '0;
		end else begin
			if (tx_valid) begin
				buf_full <= 1'b1;
			end else if (credit_return) begin
				buf_full <= 1'b0;
			end
			bit_cnt <= bit_end ? '0 : bit_cnt + 1'b1;
			case (state)
				mpu_periph_pkg::tx_idle: begin
					bit_cnt <= '0;
					if (buf_full) begin
						state <= mpu_periph_pkg::tx_start;
					end
				end
				mpu_periph_pkg::tx_start: begin
					if (bit_end) begin
						state   <= mpu_periph_pkg::tx_data;
						bit_idx <= '0;
					end
				end
				mpu_periph_pkg::tx_data: begin
					if (bit_end) begin
						if (bit_idx == $bits(bit_idx)'(mpu_periph_pkg::frame_bits - 1)) begin
							state <= mpu_periph_pkg::tx_stop;
						end else begin
							bit_idx <= bit_idx + 1'b1;
						end
					end
				end
				default: begin
					if (bit_end) begin
						state <= mpu_periph_pkg::tx_idle;
					end
				end
			endcase
		end
	end

endmodule

// File: mpu_periph_top.sv
// Top level of the peripheral block, connecting the decoder, timer and UART transmit path
module mpu_periph_top #(
	parameter int fifo_depth = 4
) (
	input  logic                           clk_sys,
	input  logic                           reset_n,
	input  logic                           cmd_valid,
	input  logic                           cmd_wr,
	input  logic [mpu_map_pkg::addr_w-1:0] cmd_addr,
	input  mpu_map_pkg::bus_word_t         cmd_data,
	output logic                           rsp_ready,
	output mpu_map_pkg::bus_word_t         rsp_data,
	input  logic                           bridge_wr,
	input  logic                           bridge_rd,
	input  logic [mpu_map_pkg::addr_w-1:0] bridge_addr,
	input  mpu_map_pkg::bus_word_t         bridge_wr_data,
	output mpu_map_pkg::bus_word_t         bridge_rd_data,
	output logic                           target_dataslot_read,
	output logic                           target_dataslot_write,
	input  logic                           target_dataslot_ack,
	input  logic                           target_dataslot_done,
	input  logic [2:0]                     target_dataslot_err,
	output logic [15:0]                    target_dataslot_id,
	output mpu_map_pkg::bus_word_t         target_dataslot_bridge_addr,
	output mpu_map_pkg::bus_word_t         target_dataslot_length,
	output mpu_map_pkg::bus_word_t         target_dataslot_slot_offset,
	input  mpu_map_pkg::bus_word_t         core_input,
	output mpu_map_pkg::bus_word_t         core_output,
	output logic                           ext_irq,
	output logic                           timer_irq,
	output logic                           txd
);

	timer_ctrl_if timer_ctrl ();

	logic                       push, full;
	mpu_periph_pkg::uart_byte_t push_byte;
	mpu_map_pkg::bus_word_t     uart_divisor;
	logic                       tx_valid, credit_return;
	mpu_periph_pkg::uart_byte_t tx_byte;

	mpu_reg_decoder decoder_i (
		.clk_sys, .reset_n,
		.cmd_valid, .cmd_wr, .cmd_addr, .cmd_data, .rsp_ready, .rsp_data,
		.bridge_wr, .bridge_rd, .bridge_addr, .bridge_wr_data, .bridge_rd_data,
		.target_dataslot_read, .target_dataslot_write,
		.target_dataslot_ack, .target_dataslot_done, .target_dataslot_err,
		.target_dataslot_id, .target_dataslot_bridge_addr,
		.target_dataslot_length, .target_dataslot_slot_offset,
		.core_input, .core_output, .ext_irq, .timer_irq,
		.timer (timer_ctrl.decoder),
		.push, .push_byte, .full, .uart_divisor
	);

	ms_timer timer_i (
		.clk_sys, .reset_n,
		.ctrl (timer_ctrl.timer)
	);

	// Credit handshake between FIFO and serializer
	uart_tx_fifo #(.fifo_depth(fifo_depth)) tx_fifo_i (
		.clk_sys, .reset_n,
		.push, .push_byte, .full,
		.tx_valid, .tx_byte, .credit_return
	);

	uart_tx_serializer tx_ser_i (
		.clk_sys, .reset_n,
		.tx_valid, .tx_byte, .credit_return,
		.uart_divisor, .txd
	);

endmodule

// File: mpu_periph_tb.sv
// Self-checking testbench for the peripheral block; build and run it through the Makefile targets
module mpu_periph_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int fifo_depth = 4;
	localparam int uart_div   = 4;
	localparam int tick_len   = 9;  // ticks_per_ms, so 10 cycles per millisecond
	localparam int table_len  = 27;
	// Bytes held at once by the FIFO entries, the credited buffer and the shifter
	localparam int capacity   = fifo_depth + mpu_periph_pkg::tx_credits + 1;
	localparam int timeout_cycles = 20 * table_len + 12 * uart_div * 10;

	localparam mpu_map_pkg::bus_word_t ds_id_val    = 32'hABCD_5A17;
	localparam mpu_map_pkg::bus_word_t ds_addr_val  = 32'h2000_0400;
	localparam mpu_map_pkg::bus_word_t ds_len_val   = 32'h0001_8000;
	localparam mpu_map_pkg::bus_word_t ds_offs_val  = 32'h0000_0C00;
	localparam mpu_map_pkg::bus_word_t core_out_val = 32'h8421_0F0F;
	localparam mpu_map_pkg::bus_word_t core_in_val  = 32'h3C5A_96E1;

	typedef enum logic [1:0] {cpu_write, cpu_read, bridge_write, bridge_read} op_e;

	typedef struct packed {
		op_e                      op;
		mpu_map_pkg::reg_offset_e offset;
		mpu_map_pkg::bus_word_t   data;
		mpu_map_pkg::bus_word_t   expected; // Read ops only
	} step_t;

	logic                           clk_sys;
	logic                           reset_n;
	logic                           cmd_valid;
	logic                           cmd_wr;
	logic [mpu_map_pkg::addr_w-1:0] cmd_addr;
	mpu_map_pkg::bus_word_t         cmd_data;
	logic                           rsp_ready;
	mpu_map_pkg::bus_word_t         rsp_data;
	logic                           bridge_wr;
	logic                           bridge_rd;
	logic [mpu_map_pkg::addr_w-1:0] bridge_addr;
	mpu_map_pkg::bus_word_t         bridge_wr_data;
	mpu_map_pkg::bus_word_t         bridge_rd_data;
	logic                           target_dataslot_read;
	logic                           target_dataslot_write;
	logic                           target_dataslot_ack;
	logic                           target_dataslot_done;
	logic [2:0]                     target_dataslot_err;
	logic [15:0]                    target_dataslot_id;
	mpu_map_pkg::bus_word_t         target_dataslot_bridge_addr;
	mpu_map_pkg::bus_word_t         target_dataslot_length;
	mpu_map_pkg::bus_word_t         target_dataslot_slot_offset;
	mpu_map_pkg::bus_word_t         core_input;
	mpu_map_pkg::bus_word_t         core_output;
	logic                           ext_irq;
	logic                           timer_irq;
	logic                           txd;

	step_t                      steps [table_len];
	int                         step_count = 0;
	int                         cycle_count = 0;
	mpu_periph_pkg::uart_byte_t rx_q [$];  // Bytes seen on txd
	mpu_periph_pkg::uart_byte_t exp_q [$]; // Bytes expected on txd

	mpu_periph_top #(.fifo_depth(fifo_depth)) dut_i (.*);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	task automatic report_failure(input string reason);
		$display("%s", reason);
		$display("*** FAILED ***");
		$fatal(1, "Run stopped at the first failure");
	endtask

	task automatic check_word(input string name, input mpu_map_pkg::bus_word_t got,
		input mpu_map_pkg::bus_word_t expected);
		if (got !== expected) begin
			report_failure($sformatf("ERROR %s: got 0x%h, expected 0x%h", name, got, expected));
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic expected);
		if (got !== expected) begin
			report_failure($sformatf("ERROR %s: got 0x%h, expected 0x%h", name, got, expected));
		end
	endtask

	task automatic check_byte(input string name, input mpu_periph_pkg::uart_byte_t got,
		input mpu_periph_pkg::uart_byte_t expected);
		if (got !== expected) begin
			report_failure($sformatf("ERROR %s: got 0x%h, expected 0x%h", name, got, expected));
		end
	endtask

	// Run length guard
	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == timeout_cycles) begin
			report_failure($sformatf("Timeout: the run did not finish within %0d cycles",
				timeout_cycles));
		end
	end

	function automatic logic [31:0] cpu_reg_addr(input mpu_map_pkg::reg_offset_e off);
		return {mpu_map_pkg::periph_base, off};
	endfunction

	function automatic logic [31:0] bridge_reg_addr(input mpu_map_pkg::reg_offset_e off);
		return {mpu_map_pkg::bridge_base, off};
	endfunction

	function automatic void add_step(input op_e op, input mpu_map_pkg::reg_offset_e off,
		input mpu_map_pkg::bus_word_t data, input mpu_map_pkg::bus_word_t expected);
		steps[step_count] = '{op, off, data, expected};
		step_count++;
	endfunction

	function automatic void build_table();
		mpu_map_pkg::reg_offset_e off;
		mpu_map_pkg::bus_word_t   word;
		for (int i = 0; i < 8; i++) begin
			off  = mpu_map_pkg::reg_offset_e'(8'(4 * i));
			word = $urandom();
			if (i % 2 == 0) begin // CPU to bridge on even boxes and the reverse on odd ones
				add_step(cpu_write, off, word, '0);
				add_step(bridge_read, off, '0, word);
			end else begin
				add_step(bridge_write, off, word, '0);
				add_step(cpu_read, off, '0, word);
			end
		end
		add_step(cpu_write, mpu_map_pkg::ds_id, ds_id_val, '0);
		add_step(cpu_read, mpu_map_pkg::ds_id, '0, {16'd0, ds_id_val[15:0]}); // 16-bit id
		add_step(cpu_write, mpu_map_pkg::ds_bridge_addr, ds_addr_val, '0);
		add_step(cpu_read, mpu_map_pkg::ds_bridge_addr, '0, ds_addr_val);
		add_step(cpu_write, mpu_map_pkg::ds_length, ds_len_val, '0);
		add_step(cpu_read, mpu_map_pkg::ds_length, '0, ds_len_val);
		add_step(cpu_write, mpu_map_pkg::ds_slot_offset, ds_offs_val, '0);
		add_step(cpu_read, mpu_map_pkg::ds_slot_offset, '0, ds_offs_val);
		add_step(cpu_write, mpu_map_pkg::core_out, core_out_val, '0);
		add_step(cpu_read, mpu_map_pkg::core_out, '0, core_out_val);
		add_step(cpu_read, mpu_map_pkg::core_in, '0, core_in_val);
	endfunction

	// One CPU command that returns in the response cycle
	task automatic cpu_access(input logic wr, input logic [31:0] addr,
		input mpu_map_pkg::bus_word_t data, output mpu_map_pkg::bus_word_t rdata);
		cmd_valid = 1'b1;
		cmd_wr    = wr;
		cmd_addr  = addr;
		cmd_data  = data;
		@(negedge clk_sys);
		cmd_valid = 1'b0;
		check_bit("rsp_ready", rsp_ready, 1'b1);
		rdata = rsp_data;
	endtask

	task automatic write_reg(input mpu_map_pkg::reg_offset_e off,
		input mpu_map_pkg::bus_word_t data);
		mpu_map_pkg::bus_word_t unused;
		cpu_access(1'b1, cpu_reg_addr(off), data, unused);
	endtask

	task automatic expect_reg(input mpu_map_pkg::reg_offset_e off,
		input mpu_map_pkg::bus_word_t expected);
		mpu_map_pkg::bus_word_t rdata;
		cpu_access(1'b0, cpu_reg_addr(off), '0, rdata);
		check_word($sformatf("rsp_data at %s", off.name()), rdata, expected);
	endtask

	task automatic apply_step(input step_t s);
		mpu_map_pkg::bus_word_t rdata;
		case (s.op)
			bridge_write: begin
				bridge_wr      = 1'b1;
				bridge_addr    = bridge_reg_addr(s.offset);
				bridge_wr_data = s.data;
				@(negedge clk_sys);
				bridge_wr = 1'b0;
			end
			bridge_read: begin
				bridge_rd   = 1'b1;
				bridge_addr = bridge_reg_addr(s.offset);
				@(negedge clk_sys);
				bridge_rd = 1'b0;
				@(negedge clk_sys); // Data two cycles after the request
				check_word($sformatf("bridge_rd_data at %s", s.offset.name()),
					bridge_rd_data, s.expected);
			end
			default: begin
				cpu_access(s.op == cpu_write, cpu_reg_addr(s.offset), s.data, rdata);
				if (s.op == cpu_read) begin
					check_word($sformatf("rsp_data at %s", s.offset.name()), rdata, s.expected);
				end
				@(negedge clk_sys);
				check_bit("rsp_ready one cycle later", rsp_ready, 1'b0);
			end
		endcase
	endtask

	task automatic check_go_pulse(input mpu_map_pkg::bus_word_t ctrl_word);
		write_reg(mpu_map_pkg::ds_ctrl, ctrl_word);
		check_bit("target_dataslot_read", target_dataslot_read,
			ctrl_word[mpu_map_pkg::read_go_bit]);
		check_bit("target_dataslot_write", target_dataslot_write,
			ctrl_word[mpu_map_pkg::write_go_bit]);
		@(negedge clk_sys);
		check_bit("target_dataslot_read", target_dataslot_read, 1'b0);
		check_bit("target_dataslot_write", target_dataslot_write, 1'b0);
	endtask

	// Raise done once and count ext_irq pulses
	task automatic count_ext_irq(input logic enable, input int expected);
		int pulses;
		pulses = 0;
		write_reg(mpu_map_pkg::ds_ctrl, enable ? (32'h1 << mpu_map_pkg::irq_enable_bit) : '0);
		target_dataslot_done = 1'b1;
		repeat (6) begin
			@(negedge clk_sys);
			if (ext_irq) begin
				pulses++;
			end
		end
		target_dataslot_done = 1'b0;
		@(negedge clk_sys);
		check_word("ext_irq pulse count", 32'(pulses), 32'(expected));
	endtask

	task automatic compare_frames(input int n);
		mpu_periph_pkg::uart_byte_t got;
		mpu_periph_pkg::uart_byte_t expected;
		while (rx_q.size() < n) begin
			@(negedge clk_sys);
		end
		for (int i = 0; i < n; i++) begin
			got      = rx_q.pop_front();
			expected = exp_q.pop_front();
			check_byte($sformatf("txd frame %0d", i), got, expected);
		end
	endtask

	// UART monitor sampling each bit near its middle
	initial begin
		mpu_periph_pkg::uart_byte_t rx_byte;
		forever begin
			@(negedge txd);
			repeat (uart_div / 2) @(negedge clk_sys);
			check_bit("txd start bit", txd, 1'b0);
			for (int i = 0; i < mpu_periph_pkg::frame_bits; i++) begin
				repeat (uart_div) @(negedge clk_sys);
				rx_byte[i] = txd; // LSB first
			end
			repeat (uart_div) @(negedge clk_sys);
			check_bit("txd stop bit", txd, 1'b1);
			rx_q.push_back(rx_byte);
		end
	end

	initial begin
		mpu_map_pkg::bus_word_t     rdata;
		mpu_periph_pkg::uart_byte_t b;
		int                         waited;
		void'($urandom(32'h564));
		reset_n              = 1'b0;
		cmd_valid            = 1'b0;
		cmd_wr               = 1'b0;
		cmd_addr             = '0;
		cmd_data             = '0;
		bridge_wr            = 1'b0;
		bridge_rd            = 1'b0;
		bridge_addr          = '0;
		bridge_wr_data       = '0;
		target_dataslot_ack  = 1'b0;
		target_dataslot_done = 1'b0;
		target_dataslot_err  = '0;
		core_input           = core_in_val;
		build_table();
		repeat (10) @(negedge clk_sys);
		check_bit("rsp_ready", rsp_ready, 1'b0);
		check_bit("target_dataslot_read", target_dataslot_read, 1'b0);
		check_bit("target_dataslot_write", target_dataslot_write, 1'b0);
		check_bit("ext_irq", ext_irq, 1'b0);
		check_bit("timer_irq", timer_irq, 1'b0);
		check_bit("txd", txd, 1'b1);
		reset_n = 1'b1;
		@(negedge clk_sys);

		foreach (steps[i]) begin
			apply_step(steps[i]);
		end
		check_word("target_dataslot_id", {16'd0, target_dataslot_id}, {16'd0, ds_id_val[15:0]});
		check_word("target_dataslot_bridge_addr", target_dataslot_bridge_addr, ds_addr_val);
		check_word("target_dataslot_length", target_dataslot_length, ds_len_val);
		check_word("target_dataslot_slot_offset", target_dataslot_slot_offset, ds_offs_val);
		check_word("core_output", core_output, core_out_val);

		// Same offset as core_in but outside the peripheral region
		cpu_access(1'b0, {24'h123456, mpu_map_pkg::core_in}, '0, rdata);
		check_word("rsp_data outside region", rdata, '0);

		check_go_pulse(32'h1 << mpu_map_pkg::read_go_bit);
		check_go_pulse(32'h1 << mpu_map_pkg::write_go_bit);
		target_dataslot_ack = 1'b1;
		target_dataslot_err = 3'b101;
		@(negedge clk_sys);
		expect_reg(mpu_map_pkg::ds_ctrl, {27'd0, 1'b1, 1'b0, 3'b101}); // ack, done, err
		count_ext_irq(1'b1, 1);
		count_ext_irq(1'b0, 0);

		// Count after clear lags by the strobe, tick and count registers
		write_reg(mpu_map_pkg::ticks_per_ms, tick_len);
		write_reg(mpu_map_pkg::timer_count, 32'd1);
		write_reg(mpu_map_pkg::timer_limit, 32'd3);
		repeat (33) @(negedge clk_sys); // Read lands 35 cycles after the clear
		expect_reg(mpu_map_pkg::timer_count, (35 - 3) / (tick_len + 1));
		check_bit("timer_irq while masked", timer_irq, 1'b0);
		write_reg(mpu_map_pkg::irq_mask, 32'd1);
		@(negedge clk_sys);
		check_bit("timer_irq after unmask", timer_irq, 1'b1);
		write_reg(mpu_map_pkg::timer_count, 32'd1);
		@(negedge clk_sys);
		check_bit("timer_irq after clear", timer_irq, 1'b0);
		write_reg(mpu_map_pkg::timer_limit, 32'd2);
		waited = 0;
		while (!timer_irq) begin
			@(negedge clk_sys);
			waited++;
			if (waited > 3 * (tick_len + 1)) begin
				report_failure("timer_irq did not rise after the count reached the limit");
			end
		end
		expect_reg(mpu_map_pkg::timer_count, 32'd2);

		write_reg(mpu_map_pkg::uart_divisor, uart_div);
		for (int i = 0; i < 3; i++) begin
			b = 8'($urandom());
			exp_q.push_back(b);
			write_reg(mpu_map_pkg::uart_data, {24'd0, b});
		end
		compare_frames(3);

		// Burst past the capacity so the extra bytes are dropped
		repeat (2 * uart_div) @(negedge clk_sys);
		for (int k = 0; k < capacity + 2; k++) begin
			b = 8'($urandom());
			write_reg(mpu_map_pkg::uart_data, {24'd0, b});
			if (k < capacity) begin
				exp_q.push_back(b);
			end
			@(negedge clk_sys);
			expect_reg(mpu_map_pkg::uart_data, (k + 1 >= capacity) ? (32'h1 << 8) : 32'h0);
		end
		compare_frames(capacity);
		repeat (12 * uart_div) @(negedge clk_sys);
		check_word("frames after the dropped writes", 32'(rx_q.size()), '0);

		$display("*** PASSED ***");
		$finish;
	end

endmodule

// File: files.f
mpu_map_pkg.sv
mpu_periph_pkg.sv
timer_ctrl_if.sv
mpu_reg_decoder.sv
ms_timer.sv
uart_tx_fifo.sv
uart_tx_serializer.sv
mpu_periph_top.sv
mpu_periph_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= mpu_periph_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --timescale 1ns/100ps
SIM_BIN   ?= $(OBJ_DIR)/V$(TOP)

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
